//--- branch_fu.sv
`include "branch_params.svh"

module branch_fu (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  isa_pkg::addr_t       pc,
    input  isa_pkg::inst_t       inst,
    input  isa_pkg::data_t       rs1_value,
    input  isa_pkg::data_t       rs2_value,
    input  logic                 pred_taken,
    input  isa_pkg::addr_t       pred_target,
    input  branch_pkg::br_mask_t br_id,
    input  branch_pkg::br_mask_t br_mask,
    input  branch_pkg::br_task_t rem_task,
    input  branch_pkg::br_mask_t rem_id,
    output logic                 result_valid,
    output isa_pkg::addr_t       result,
    output isa_pkg::addr_t       target_addr,
    output logic                 br_taken,
    output logic                 pred_correct,
    output branch_pkg::br_task_t br_task,
    output branch_pkg::br_mask_t res_id,
    output branch_pkg::br_mask_t res_mask
);
    import isa_pkg::*;
    import branch_pkg::*;

    opcode_t  opcode;
    funct3_t  funct3;
    logic     uncond;
    logic     cond_taken;
    logic     taken;
    logic     correct;
    logic     squash_hit;
    addr_t    branch_target;
    addr_t    link;
    addr_t    next_target;
    br_mask_t cur_mask;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign uncond = (opcode == OP_JAL) || (opcode == OP_JALR);

    branch_target_adder target_adder_i (
        .pc        (pc),
        .inst      (inst),
        .rs1_value (rs1_value),
        .target    (branch_target)
    );

    always_comb begin
        case (funct3)
            3'b000:  cond_taken = rs1_value == rs2_value;                    // BEQ
            3'b001:  cond_taken = rs1_value != rs2_value;                    // BNE
            3'b100:  cond_taken = $signed(rs1_value) <  $signed(rs2_value);  // BLT
            3'b101:  cond_taken = $signed(rs1_value) >= $signed(rs2_value);  // BGE
            3'b110:  cond_taken = rs1_value <  rs2_value;                    // BLTU
            3'b111:  cond_taken = rs1_value >= rs2_value;                    // BGEU
            default: cond_taken = 1'b0;
        endcase
    end

    assign taken = uncond || cond_taken;
    assign link  = pc + addr_t'(ILEN_BYTES);

    // Target only matters on a taken branch
    assign correct = (pred_taken == taken) && (!taken || (pred_target == branch_target));

    assign next_target = taken ? branch_target : link;

    // Broadcast landing in the issue cycle
    assign squash_hit = (rem_task == `BR_SQUASH) && ((br_mask & rem_id) != '0);
    assign cur_mask   = (rem_task == `BR_CLEAR) ? (br_mask & ~rem_id) : br_mask;

    always_ff @(posedge clock) begin
        if (rst) begin
            result_valid <= 1'b0;
            br_task      <= `BR_NOTHING;
        end else if (issue_valid && !squash_hit) begin
            result_valid <= 1'b1;
            br_task      <= correct ? `BR_CLEAR : `BR_SQUASH;
        end else begin
            result_valid <= 1'b0;
            br_task      <= `BR_NOTHING;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result       <= link;
            target_addr  <= next_target;
            br_taken     <= taken;
            pred_correct <= correct;
            res_id       <= br_id;
            res_mask     <= cur_mask;
        end
    end

endmodule

//--- branch_params.svh
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// Datapath and address width
`define XLEN 32

// In-flight branch tags, one bit each
`define NUM_BR 4

`define BR_NOTHING 2'd0
`define BR_CLEAR   2'd1
`define BR_SQUASH  2'd2

`endif

//--- branch_pkg.sv
`include "branch_params.svh"

package branch_pkg;

    // One bit per in-flight branch
    typedef logic [`NUM_BR-1:0] br_mask_t;

    // NOTHING, CLEAR or SQUASH
    typedef logic [1:0] br_task_t;

endpackage

//--- branch_tag_tracker.sv
`include "branch_params.svh"

module branch_tag_tracker (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 alloc_req,
    input  logic                 result_valid,
    input  branch_pkg::br_task_t br_task,
    input  branch_pkg::br_mask_t res_id,
    output logic                 alloc_ok,
    output branch_pkg::br_mask_t alloc_id,
    output branch_pkg::br_mask_t alloc_mask,
    output branch_pkg::br_mask_t busy_mask,
    output branch_pkg::br_task_t rem_task,
    output branch_pkg::br_mask_t rem_id
);
    import branch_pkg::*;

    br_mask_t busy;
    br_mask_t free;
    br_mask_t kill;
    br_mask_t dep [`NUM_BR];
    logic     alloc_fire;

    assign free     = ~busy;
    assign alloc_ok = free != '0;

    // Isolate the lowest set bit of the free set
    assign alloc_id   = free & (~free + br_mask_t'(1));
    assign alloc_mask = busy;
    assign busy_mask  = busy;

    assign alloc_fire = alloc_req && alloc_ok;

    // Tags released by the broadcast now on rem_task
    always_comb begin
        kill = '0;
        if (rem_task == `BR_CLEAR) begin
            kill = rem_id;
        end else if (rem_task == `BR_SQUASH) begin
            kill = rem_id;
            for (int i = 0; i < `NUM_BR; i++) begin
                if (busy[i] && ((dep[i] & rem_id) != '0)) begin
                    kill[i] = 1'b1;  // Younger dependent
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            busy     <= '0;
            rem_task <= `BR_NOTHING;
        end else begin
            busy     <= (busy & ~kill) | (alloc_fire ? alloc_id : br_mask_t'(0));
            rem_task <= result_valid ? br_task : `BR_NOTHING;
        end
    end

    always_ff @(posedge clock) begin
        if (result_valid) begin
            rem_id <= res_id;
        end
    end

    // Dependencies are the older live tags at allocation
    always_ff @(posedge clock) begin
        for (int i = 0; i < `NUM_BR; i++) begin
            if (alloc_fire && alloc_id[i]) begin
                dep[i] <= busy & ~kill;
            end else begin
                dep[i] <= dep[i] & ~kill;  // Drop resolved tags
            end
        end
    end

endmodule

//--- branch_target_adder.sv
`include "branch_params.svh"

module branch_target_adder (
    input  isa_pkg::addr_t pc,
    input  isa_pkg::inst_t inst,
    input  isa_pkg::data_t rs1_value,
    output isa_pkg::addr_t target
);
    import isa_pkg::*;

    opcode_t opcode;
    data_t   imm_b;
    data_t   imm_j;
    data_t   imm_i;
    data_t   imm;
    addr_t   base;
    addr_t   sum;

    assign opcode = inst[6:0];

    // Sign-extended immediates, bit 0 implied zero for B and J
    assign imm_b = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_i = {{(`XLEN-11){inst[31]}}, inst[30:20]};

    always_comb begin
        case (opcode)
            OP_JAL: begin
                imm  = imm_j;
                base = pc;
            end
            OP_JALR: begin
                imm  = imm_i;
                base = rs1_value;  // Register-relative
            end
            default: begin
                imm  = imm_b;
                base = pc;
            end
        endcase
    end

    assign sum = base + imm;

    // JALR drops the low bit of the sum
    assign target = (opcode == OP_JALR) ? {sum[`XLEN-1:1], 1'b0} : sum;

endmodule

//--- branch_unit.sv
module branch_unit (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  isa_pkg::addr_t       pc,
    input  isa_pkg::inst_t       inst,
    input  isa_pkg::data_t       rs1_value,
    input  isa_pkg::data_t       rs2_value,
    input  logic                 pred_taken,
    input  isa_pkg::addr_t       pred_target,
    input  branch_pkg::br_mask_t br_id,
    input  branch_pkg::br_mask_t br_mask,
    input  logic                 alloc_req,
    output logic                 result_valid,
    output isa_pkg::addr_t       result,
    output isa_pkg::addr_t       target_addr,
    output logic                 br_taken,
    output logic                 pred_correct,
    output branch_pkg::br_task_t br_task,
    output branch_pkg::br_mask_t res_id,
    output branch_pkg::br_mask_t res_mask,
    output branch_pkg::br_task_t rem_task,
    output branch_pkg::br_mask_t rem_id,
    output logic                 alloc_ok,
    output branch_pkg::br_mask_t alloc_id,
    output branch_pkg::br_mask_t alloc_mask,
    output branch_pkg::br_mask_t busy_mask
);

    branch_fu fu_i (
        .clock, .rst, .issue_valid, .pc, .inst, .rs1_value, .rs2_value,
        .pred_taken, .pred_target, .br_id, .br_mask,
        .rem_task, .rem_id,
        .result_valid, .result, .target_addr, .br_taken, .pred_correct,
        .br_task, .res_id, .res_mask
    );

    // Resolutions loop back as broadcasts one cycle later
    branch_tag_tracker tracker_i (
        .clock        (clock),
        .rst          (rst),
        .alloc_req    (alloc_req),
        .result_valid (result_valid),
        .br_task      (br_task),
        .res_id       (res_id),
        .alloc_ok     (alloc_ok),
        .alloc_id     (alloc_id),
        .alloc_mask   (alloc_mask),
        .busy_mask    (busy_mask),
        .rem_task     (rem_task),
        .rem_id       (rem_id)
    );

endmodule

//--- branch_unit_assert.sv
`include "branch_params.svh"

module branch_unit_assert (
    input logic                 clock,
    input logic                 rst,
    input logic                 result_valid,
    input branch_pkg::br_mask_t res_id,
    input branch_pkg::br_task_t rem_task,
    input branch_pkg::br_mask_t rem_id,
    input logic                 alloc_ok,
    input branch_pkg::br_mask_t alloc_id,
    input branch_pkg::br_mask_t busy_mask
);
    import branch_pkg::*;

    int error_count = 0;

    // A resolving branch still owns a live tag
    resolve_live_a: assert property (@(posedge clock) disable iff (rst)
        result_valid |-> ((res_id & busy_mask) != '0))
        else begin
            error_count++;
            $error("Result carries a tag that is not busy");
        end

    release_a: assert property (@(posedge clock) disable iff (rst)
        (rem_task != `BR_NOTHING) |=> ((busy_mask & $past(rem_id)) == '0))
        else begin
            error_count++;
            $error("Broadcast tag still busy after the broadcast");
        end

    // Pending broadcast tag is never handed out again
    alloc_fresh_a: assert property (@(posedge clock) disable iff (rst)
        (alloc_ok && (rem_task != `BR_NOTHING)) |-> ((alloc_id & rem_id) == '0))
        else begin
            error_count++;
            $error("alloc_id offers the tag that is being broadcast");
        end

    rem_onehot_a: assert property (@(posedge clock) disable iff (rst)
        (rem_task != `BR_NOTHING) |-> $onehot(rem_id))
        else begin
            error_count++;
            $error("rem_id is not one-hot during a broadcast");
        end

endmodule

//--- branch_unit_tb.sv
`include "branch_params.svh"

module branch_unit_tb;
    import isa_pkg::*;
    import branch_pkg::*;

    localparam int WAIT_LIMIT = 8;

    typedef struct packed {
        logic [1:0] kind;        // 0 branch, 1 JAL, 2 JALR
        funct3_t    funct3;
        data_t      imm;
        addr_t      pc;
        data_t      rs1;
        data_t      rs2;
        logic       pred_taken;
        logic       pred_hit;    // Predicted target is the real one
    } row_t;

    logic     clock, rst, issue_valid, pred_taken, alloc_req;
    logic     result_valid, br_taken, pred_correct, alloc_ok;
    addr_t    pc, pred_target, result, target_addr;
    inst_t    inst;
    data_t    rs1_value, rs2_value;
    br_task_t br_task, rem_task, res_task;
    br_mask_t br_id, br_mask, res_id, res_mask, rem_id, alloc_id, alloc_mask, busy_mask;
    br_mask_t tag_a, tag_b, tag_c;
    br_mask_t exp_busy;
    br_mask_t exp_dep [`NUM_BR];  // Older tags seen at allocation
    row_t     rows_q [$];
    row_t     good_row, bad_row;

    branch_unit dut_i (.*);

    bind branch_unit branch_unit_assert assert_i (
        .clock(clock), .rst(rst), .result_valid(result_valid), .res_id(res_id),
        .rem_task(rem_task), .rem_id(rem_id), .alloc_ok(alloc_ok), .alloc_id(alloc_id),
        .busy_mask(busy_mask)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic row_t make_row(logic [1:0] kind, funct3_t f3, data_t imm, addr_t pc_v,
                                      data_t a, data_t b, logic ptaken, logic phit);
        row_t r;
        r = '{kind, f3, imm, pc_v, a, b, ptaken, phit};
        if (kind != 2'd0) r.rs2 = $urandom;  // Unused operands get fill values
        if (kind == 2'd1) r.rs1 = $urandom;
        return r;
    endfunction

    function automatic inst_t encode(row_t r);
        logic [31:0] m;
        m = r.imm;
        case (r.kind)
            2'd1:    return {m[20], m[10:1], m[11], m[19:12], 5'd1, 7'b1101111};
            2'd2:    return {m[11:0], 5'd5, 3'b000, 5'd1, 7'b1100111};
            default: return {m[12], m[10:5], 5'd6, 5'd5, r.funct3, m[4:1], m[11], 7'b1100011};
        endcase
    endfunction

    function automatic logic will_take(row_t r);
        if (r.kind != 2'd0) return 1'b1;
        case (r.funct3)
            3'b000:  return r.rs1 == r.rs2;
            3'b001:  return r.rs1 != r.rs2;
            3'b100:  return $signed(r.rs1) < $signed(r.rs2);
            3'b101:  return $signed(r.rs1) >= $signed(r.rs2);
            3'b110:  return r.rs1 < r.rs2;
            default: return r.rs1 >= r.rs2;
        endcase
    endfunction

    function automatic addr_t jump_dest(row_t r);
        if (r.kind == 2'd2) return (r.rs1 + r.imm) & ~addr_t'(1);
        return r.pc + r.imm;
    endfunction

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        stop_on_error();
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_task(string name, br_task_t got, br_task_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_mask(string name, br_mask_t got, br_mask_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    always @(dut_i.assert_i.error_count) begin
        if (dut_i.assert_i.error_count != 0) begin
            $display("A bound assertion failed at time %0t", $time);
            stop_on_error();
        end
    end

    task automatic alloc_tag(output br_mask_t tag);
        br_mask_t exp_tag;
        exp_tag = '0;
        for (int i = `NUM_BR - 1; i >= 0; i--) begin
            if (!exp_busy[i]) exp_tag = br_mask_t'(1) << i;  // Lowest free wins
        end
        check_bit("alloc_ok", alloc_ok, exp_tag != '0);
        check_mask("alloc_id", alloc_id, exp_tag);
        check_mask("alloc_mask", alloc_mask, exp_busy);
        for (int i = 0; i < `NUM_BR; i++) begin
            if (exp_tag[i]) exp_dep[i] = exp_busy;
        end
        tag = exp_tag;
        alloc_req = 1'b1;
        @(negedge clock);
        alloc_req = 1'b0;
        exp_busy = exp_busy | exp_tag;
        check_mask("busy_mask after alloc", busy_mask, exp_busy);
    endtask

    task automatic drive_issue(row_t r, br_mask_t tag, br_mask_t mask);
        issue_valid = 1'b1;
        pc = r.pc;
        inst = encode(r);
        rs1_value = r.rs1;
        rs2_value = r.rs2;
        pred_taken = r.pred_taken;
        pred_target = r.pred_hit ? jump_dest(r) : jump_dest(r) + 8;
        br_id = tag;
        br_mask = mask;
    endtask

    task automatic expect_result(row_t r, br_mask_t tag, br_mask_t mask_exp,
                                 output br_task_t task_exp);
        int    cycles;
        logic  taken;
        logic  correct;
        taken = will_take(r);
        correct = (r.pred_taken == taken) && (!taken || r.pred_hit);
        cycles = 0;
        do begin
            @(negedge clock);
            issue_valid = 1'b0;
            cycles++;
        end while (result_valid !== 1'b1 && cycles < WAIT_LIMIT);
        if (result_valid !== 1'b1) begin
            $display("Timeout: the branch result never came after %0d cycles", cycles);
            stop_on_error();
        end
        task_exp = correct ? `BR_CLEAR : `BR_SQUASH;
        check_bit("result latency of one cycle", cycles == 1, 1'b1);
        check_bit("br_taken", br_taken, taken);
        check_bit("pred_correct", pred_correct, correct);
        check_addr("target_addr", target_addr, taken ? jump_dest(r) : r.pc + 4);
        check_addr("result", result, r.pc + 4);
        check_task("br_task", br_task, task_exp);
        check_mask("res_id", res_id, tag);
        check_mask("res_mask", res_mask, mask_exp);
    endtask

    task automatic expect_broadcast(br_task_t task_exp, br_mask_t tag);
        int       cycles;
        br_mask_t kill;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (rem_task === `BR_NOTHING && cycles < WAIT_LIMIT);
        if (rem_task === `BR_NOTHING) begin
            $display("Timeout: the branch broadcast never came after %0d cycles", cycles);
            stop_on_error();
        end
        check_bit("broadcast one cycle after result", cycles == 1, 1'b1);
        check_bit("result_valid single pulse", result_valid, 1'b0);
        check_task("rem_task", rem_task, task_exp);
        check_mask("rem_id", rem_id, tag);
        kill = tag;
        for (int i = 0; i < `NUM_BR; i++) begin
            if (task_exp == `BR_SQUASH && exp_busy[i] && (exp_dep[i] & tag) != '0) kill[i] = 1'b1;
        end
        exp_busy = exp_busy & ~kill;
        for (int i = 0; i < `NUM_BR; i++) exp_dep[i] = exp_dep[i] & ~kill;
    endtask

    initial begin
        void'($urandom(33));
        rst = 1'b1;
        issue_valid = 1'b0;
        pc = '0;
        inst = '0;
        rs1_value = '0;
        rs2_value = '0;
        pred_taken = 1'b0;
        pred_target = '0;
        br_id = '0;
        br_mask = '0;
        alloc_req = 1'b0;
        exp_busy = '0;
        for (int i = 0; i < `NUM_BR; i++) exp_dep[i] = '0;
        repeat (5) @(negedge clock);
        rst = 1'b0;
        check_bit("result_valid after reset", result_valid, 1'b0);
        check_task("br_task after reset", br_task, `BR_NOTHING);
        check_task("rem_task after reset", rem_task, `BR_NOTHING);
        check_mask("busy_mask after reset", busy_mask, '0);

        // kind, funct3, imm, pc, rs1, rs2, pred_taken, pred_hit
        good_row = make_row(0, 3'b000, 32'd64, 32'h1000, 32'h55, 32'h55, 1, 1);
        bad_row  = make_row(0, 3'b001, 32'hFFFFFFF0, 32'h1020, 7, 7, 1, 1);
        rows_q.push_back(good_row);
        rows_q.push_back(make_row(0, 3'b000, 32'd64, 32'h1010, 5, 6, 0, 1));
        rows_q.push_back(bad_row);
        rows_q.push_back(make_row(0, 3'b100, 32'hFFFFFF00, 32'h2000, 32'hFFFFFFFF, 1, 1, 1));
        rows_q.push_back(make_row(0, 3'b110, 32'd128, 32'h2004, 32'hFFFFFFFF, 1, 1, 1));
        rows_q.push_back(make_row(0, 3'b101, 32'd2048, 32'h2008, 1, 32'hFFFFFFFF, 0, 1));
        rows_q.push_back(make_row(0, 3'b111, 32'd8, 32'h200C, 1, 32'hFFFFFFFF, 0, 1));
        rows_q.push_back(make_row(0, 3'b101, 32'd12, 32'h2010, 32'h80000000, 32'h80000000, 1, 1));
        rows_q.push_back(make_row(0, 3'b100, 32'd32, 32'h2014, 32'h80000000, 0, 1, 0));
        rows_q.push_back(make_row(0, 3'b110, 32'hFFFFFFFC, 32'h3010, 1, 32'hFFFFFFFF, 1, 1));
        rows_q.push_back(make_row(1, 3'b000, 32'h00010000, 32'h3000, 0, 0, 1, 1));
        rows_q.push_back(make_row(1, 3'b000, 32'hFFFFF800, 32'h3004, 0, 0, 1, 0));
        rows_q.push_back(make_row(2, 3'b000, 32'd5, 32'h3008, 32'h4000, 0, 1, 1));
        rows_q.push_back(make_row(2, 3'b000, 32'hFFFFFFFC, 32'h300C, 32'h5000, 0, 0, 1));

        foreach (rows_q[i]) begin
            alloc_tag(tag_a);
            drive_issue(rows_q[i], tag_a, '0);
            expect_result(rows_q[i], tag_a, '0, res_task);
            expect_broadcast(res_task, tag_a);
            @(negedge clock);
            check_mask("busy_mask after broadcast", busy_mask, exp_busy);
        end

        // Squash of the oldest tag takes its younger dependents along
        alloc_tag(tag_a);
        alloc_tag(tag_b);
        alloc_tag(tag_c);
        drive_issue(bad_row, tag_a, '0);
        expect_result(bad_row, tag_a, '0, res_task);
        expect_broadcast(res_task, tag_a);
        drive_issue(good_row, tag_b, tag_a);  // Lands on the squash
        @(negedge clock);
        issue_valid = 1'b0;
        check_bit("result_valid of squashed issue", result_valid, 1'b0);
        check_task("rem_task after squashed issue", rem_task, `BR_NOTHING);
        check_mask("busy_mask after squash", busy_mask, exp_busy);

        // Clear of an older tag while a dependent issues
        alloc_tag(tag_a);
        alloc_tag(tag_b);
        alloc_tag(tag_c);
        drive_issue(good_row, tag_a, '0);
        expect_result(good_row, tag_a, '0, res_task);
        expect_broadcast(res_task, tag_a);
        drive_issue(good_row, tag_c, tag_a | tag_b);
        expect_result(good_row, tag_c, tag_b, res_task);
        check_mask("busy_mask after clear", busy_mask, exp_busy);
        expect_broadcast(res_task, tag_c);
        @(negedge clock);
        check_mask("busy_mask at end", busy_mask, exp_busy);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- isa_pkg.sv
`include "branch_params.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [31:0]      inst_t;
    typedef logic [2:0]       funct3_t;
    typedef logic [6:0]       opcode_t;

    localparam opcode_t OP_BRANCH = 7'b1100011;  // BEQ .. BGEU
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    localparam int ILEN_BYTES = 4;  // Fixed 32-bit encoding, no compressed

endpackage

//--- verilog.f
+incdir+.
isa_pkg.sv
branch_pkg.sv
branch_target_adder.sv
branch_fu.sv
branch_tag_tracker.sv
branch_unit.sv
branch_unit_assert.sv
branch_unit_tb.sv
